//--- hw/rvmon_commit_if.sv
`timescale 1ns/1ps

interface rvmon_commit_if;
   import rvmon_pkg::*;

   // single-cycle pulse at the end of an instruction that writes rd.
   logic commit;
   reg_idx_t rd_addr;
   word_t rd_data;
   csr_sel_t csr_sel;
   word_t csr_data;
   // single-cycle pulse for every retired instruction.
   logic retire;

   modport capture (
      output commit,
      output rd_addr,
      output rd_data,
      output csr_sel,
      output csr_data,
      output retire
   );

   modport shadow (
      input commit,
      input rd_addr,
      input rd_data,
      input csr_sel,
      input csr_data,
      input retire
   );

endinterface

//--- hw/rvmon_insn_decode.sv
`timescale 1ns/1ps

module rvmon_insn_decode (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   input  logic                   i_ibus_ack,
   input  rvmon_pkg::word_t       i_ibus_rdt,
   output rvmon_pkg::insn_class_t o_class,
   output logic                   o_class_valid
);
   import rvmon_pkg::*;

   localparam insn_class_t CLASS_OTHER = 6'd46;

   // the patterns are grouped as funct7, rs2, rs1, funct3, rd and opcode.
   function automatic insn_class_t classify(input word_t insn);
      insn_class_t c;
      casez (insn)
         32'b???????_?????_?????_???_?????_0110111 : c = 6'd0;
         32'b???????_?????_?????_???_?????_0010111 : c = 6'd1;
         32'b???????_?????_?????_???_?????_1101111 : c = 6'd2;
         32'b???????_?????_?????_000_?????_1100111 : c = 6'd3;
         // beq, bne, blt, bge, bltu and bgeu.
         32'b???????_?????_?????_000_?????_1100011 : c = 6'd4;
         32'b???????_?????_?????_001_?????_1100011 : c = 6'd5;
         32'b???????_?????_?????_100_?????_1100011 : c = 6'd6;
         32'b???????_?????_?????_101_?????_1100011 : c = 6'd7;
         32'b???????_?????_?????_110_?????_1100011 : c = 6'd8;
         32'b???????_?????_?????_111_?????_1100011 : c = 6'd9;
         // lb, lh, lw, lbu and lhu.
         32'b???????_?????_?????_000_?????_0000011 : c = 6'd10;
         32'b???????_?????_?????_001_?????_0000011 : c = 6'd11;
         32'b???????_?????_?????_010_?????_0000011 : c = 6'd12;
         32'b???????_?????_?????_100_?????_0000011 : c = 6'd13;
         32'b???????_?????_?????_101_?????_0000011 : c = 6'd14;
         // sb, sh and sw.
         32'b???????_?????_?????_000_?????_0100011 : c = 6'd15;
         32'b???????_?????_?????_001_?????_0100011 : c = 6'd16;
         32'b???????_?????_?????_010_?????_0100011 : c = 6'd17;
         // immediate ALU ops, where the shifts also check funct7.
         32'b???????_?????_?????_000_?????_0010011 : c = 6'd18;
         32'b???????_?????_?????_010_?????_0010011 : c = 6'd19;
         32'b???????_?????_?????_011_?????_0010011 : c = 6'd20;
         32'b???????_?????_?????_100_?????_0010011 : c = 6'd21;
         32'b???????_?????_?????_110_?????_0010011 : c = 6'd22;
         32'b???????_?????_?????_111_?????_0010011 : c = 6'd23;
         32'b0000000_?????_?????_001_?????_0010011 : c = 6'd24;
         32'b0000000_?????_?????_101_?????_0010011 : c = 6'd25;
         32'b0100000_?????_?????_101_?????_0010011 : c = 6'd26;
         // register ALU ops.
         32'b0000000_?????_?????_000_?????_0110011 : c = 6'd27;
         32'b0100000_?????_?????_000_?????_0110011 : c = 6'd28;
         32'b0000000_?????_?????_001_?????_0110011 : c = 6'd29;
         32'b0000000_?????_?????_010_?????_0110011 : c = 6'd30;
         32'b0000000_?????_?????_011_?????_0110011 : c = 6'd31;
         32'b0000000_?????_?????_100_?????_0110011 : c = 6'd32;
         32'b0000000_?????_?????_101_?????_0110011 : c = 6'd33;
         32'b0100000_?????_?????_101_?????_0110011 : c = 6'd34;
         32'b0000000_?????_?????_110_?????_0110011 : c = 6'd35;
         32'b0000000_?????_?????_111_?????_0110011 : c = 6'd36;
         32'b???????_?????_?????_000_?????_0001111 : c = 6'd37;
         // ecall and ebreak are only recognised as complete words.
         32'b0000000_00000_00000_000_00000_1110011 : c = 6'd38;
         32'b0000000_00001_00000_000_00000_1110011 : c = 6'd39;
         // csrrw, csrrs, csrrc and their immediate forms.
         32'b???????_?????_?????_001_?????_1110011 : c = 6'd40;
         32'b???????_?????_?????_010_?????_1110011 : c = 6'd41;
         32'b???????_?????_?????_011_?????_1110011 : c = 6'd42;
         32'b???????_?????_?????_101_?????_1110011 : c = 6'd43;
         32'b???????_?????_?????_110_?????_1110011 : c = 6'd44;
         32'b???????_?????_?????_111_?????_1110011 : c = 6'd45;
         default : c = CLASS_OTHER;
      endcase
      return c;
   endfunction

   // ########################################
   // fetch capture
   // ########################################

   always_ff @(posedge i_clk) begin
      if (i_ibus_ack) begin
         o_class <= classify(i_ibus_rdt);
      end
   end

   // the valid pulse follows the edge that loaded o_class.
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         o_class_valid <= 1'b0;
      end else begin
         o_class_valid <= i_ibus_ack;
      end
   end

endmodule

//--- hw/rvmon_pkg.sv
`include "rvmon_macros.svh"

package rvmon_pkg;

   // ########################################
   // architectural types
   // ########################################

   // register number of x0 to x31.
   typedef logic [4:0] reg_idx_t;

   typedef logic [`RVMON_XLEN-1:0] word_t;

   // one beat of the serial write-back stream.
   typedef logic [`RVMON_W-1:0] slice_t;

   // 0 selects no CSR.
   // 1 to 7 select mstatus, mie, mcause, mscratch, mtvec, mepc and mtval.
   typedef logic [2:0] csr_sel_t;

   // ########################################
   // monitor types
   // ########################################

   // codes 0 to 45 follow the RV32I and Zicsr listing order.
   // code 46 marks a word that matches no known encoding.
   typedef logic [5:0] insn_class_t;

   // byte address on the APB port.
   typedef logic [`RVMON_ADDR_W-1:0] apb_addr_t;

endpackage

//--- hw/rvmon_serial_capture.sv
`timescale 1ns/1ps
`include "rvmon_macros.svh"

module rvmon_serial_capture (
   input  logic                i_clk,
   input  logic                i_rst_n,
   input  logic                i_wen0,
   input  rvmon_pkg::slice_t   i_wdata0,
   input  logic                i_cnt_en,
   input  logic                i_csr_in,
   input  logic                i_cnt_done,
   input  logic                i_ctrl_pc_en,
   input  rvmon_pkg::reg_idx_t i_rd_addr,
   input  logic                i_csr_mstatus_en,
   input  logic                i_csr_mie_en,
   input  logic                i_csr_mcause_en,
   input  logic                i_csr_en,
   input  logic [1:0]          i_csr_addr,
   rvmon_commit_if.capture     cmt
);
   import rvmon_pkg::*;

   word_t rd_shift;
   word_t csr_shift;
   reg_idx_t rd_addr_q;
   csr_sel_t csr_sel_d;
   csr_sel_t csr_sel_q;

   // ########################################
   // serial to parallel
   // ########################################

   // slices enter at the top, so the first one ends up in the low bits.
   always_ff @(posedge i_clk) begin
      if (i_wen0) begin
         rd_shift <= {i_wdata0, rd_shift[`RVMON_XLEN-1:`RVMON_W]};
      end
      if (i_cnt_en) begin
         csr_shift <= {i_csr_in, csr_shift[`RVMON_XLEN-1:1]};
      end
   end

   // the generic enable maps addresses 0 to 3 onto codes 4 to 7.
   always_comb begin
      if (i_csr_mstatus_en) csr_sel_d = 3'd1;
      else if (i_csr_mie_en) csr_sel_d = 3'd2;
      else if (i_csr_mcause_en) csr_sel_d = 3'd3;
      else if (i_csr_en) csr_sel_d = {1'b1, i_csr_addr};
      else csr_sel_d = 3'd0;
   end

   // ########################################
   // end of instruction
   // ########################################

   always_ff @(posedge i_clk) begin
      if (i_cnt_done && i_wen0) begin
         rd_addr_q <= i_rd_addr;
         csr_sel_q <= csr_sel_d;
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         cmt.commit <= 1'b0;
         cmt.retire <= 1'b0;
      end else begin
         cmt.commit <= i_cnt_done & i_wen0;
         cmt.retire <= i_cnt_done & i_ctrl_pc_en;
      end
   end

   assign cmt.rd_addr = rd_addr_q;
   assign cmt.rd_data = rd_shift;
   assign cmt.csr_sel = csr_sel_q;
   assign cmt.csr_data = csr_shift;

endmodule

//--- hw/rvmon_shadow_regs.sv
`timescale 1ns/1ps
`include "rvmon_macros.svh"

module rvmon_shadow_regs (
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   rvmon_commit_if.shadow         cmt,
   input  rvmon_pkg::insn_class_t i_class,
   input  logic                   i_class_valid,
   input  logic                   i_psel,
   input  logic                   i_penable,
   input  logic                   i_pwrite,
   input  rvmon_pkg::apb_addr_t   i_paddr,
   output rvmon_pkg::word_t       o_prdata,
   output logic                   o_pready,
   output logic                   o_pslverr
);
   import rvmon_pkg::*;

   word_t xreg [1:31];
   word_t csr_q [1:7];
   word_t retire_cnt;
   insn_class_t pending_class;
   insn_class_t last_class;

   logic access;
   logic addr_err;
   apb_addr_t csr_off;
   csr_sel_t csr_idx;
   reg_idx_t x_idx;
   word_t rdata;

   // ########################################
   // shadow state
   // ########################################

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         for (int i = 1; i < 32; i++) begin
            xreg[i] <= '0;
         end
         for (int j = 1; j < 8; j++) begin
            csr_q[j] <= '0;
         end
         retire_cnt <= '0;
         pending_class <= '0;
         last_class <= '0;
      end else begin
         // x0 is hardwired, so writes to index 0 are dropped.
         if (cmt.commit && (cmt.rd_addr != 5'd0)) begin
            xreg[cmt.rd_addr] <= cmt.rd_data;
         end
         if (cmt.commit && (cmt.csr_sel != 3'd0)) begin
            csr_q[cmt.csr_sel] <= cmt.csr_data;
         end
         if (i_class_valid) begin
            pending_class <= i_class;
         end
         if (cmt.retire) begin
            retire_cnt <= retire_cnt + 1'b1;
            last_class <= pending_class;
         end
      end
   end

   // ########################################
   // APB read port
   // ########################################

   assign access = i_psel & i_penable;
   assign x_idx = i_paddr[6:2];
   assign csr_off = i_paddr - `RVMON_CSR_BASE;
   assign csr_idx = csr_off[4:2] + 3'd1;

   // writes are not supported and count as errors like bad addresses.
   assign addr_err = (i_paddr[1:0] != 2'b00) || (i_paddr > `RVMON_CLASS_ADDR);

   always_comb begin
      rdata = '0;
      if (i_paddr < `RVMON_CSR_BASE) begin
         if (x_idx != 5'd0) begin
            rdata = xreg[x_idx];
         end
      end else if (i_paddr < `RVMON_RETIRE_ADDR) begin
         rdata = csr_q[csr_idx];
      end else if (i_paddr == `RVMON_RETIRE_ADDR) begin
         rdata = retire_cnt;
      end else if (i_paddr == `RVMON_CLASS_ADDR) begin
         rdata = word_t'(last_class);
      end
   end

   assign o_pslverr = access & (i_pwrite | addr_err);
   assign o_prdata = (access && !i_pwrite && !addr_err) ? rdata : '0;
   assign o_pready = 1'b1;

endmodule

//--- hw/rvmon_top.sv
`timescale 1ns/1ps

module rvmon_top (
   input  logic                i_clk,
   input  logic                i_rst_n,
   input  logic                i_ibus_ack,
   input  rvmon_pkg::word_t    i_ibus_rdt,
   input  logic                i_wen0,
   input  rvmon_pkg::slice_t   i_wdata0,
   input  logic                i_cnt_en,
   input  logic                i_csr_in,
   input  logic                i_cnt_done,
   input  logic                i_ctrl_pc_en,
   input  rvmon_pkg::reg_idx_t i_rd_addr,
   input  logic                i_csr_mstatus_en,
   input  logic                i_csr_mie_en,
   input  logic                i_csr_mcause_en,
   input  logic                i_csr_en,
   input  logic [1:0]          i_csr_addr,
   input  logic                i_psel,
   input  logic                i_penable,
   input  logic                i_pwrite,
   input  rvmon_pkg::apb_addr_t i_paddr,
   output rvmon_pkg::word_t    o_prdata,
   output logic                o_pready,
   output logic                o_pslverr
);
   import rvmon_pkg::*;

   insn_class_t dec_class;
   logic dec_class_valid;

   rvmon_commit_if cmt_if ();

   rvmon_insn_decode u_decode (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .i_ibus_ack    (i_ibus_ack),
      .i_ibus_rdt    (i_ibus_rdt),
      .o_class       (dec_class),
      .o_class_valid (dec_class_valid)
   );

   rvmon_serial_capture u_capture (
      .i_clk            (i_clk),
      .i_rst_n          (i_rst_n),
      .i_wen0           (i_wen0),
      .i_wdata0         (i_wdata0),
      .i_cnt_en         (i_cnt_en),
      .i_csr_in         (i_csr_in),
      .i_cnt_done       (i_cnt_done),
      .i_ctrl_pc_en     (i_ctrl_pc_en),
      .i_rd_addr        (i_rd_addr),
      .i_csr_mstatus_en (i_csr_mstatus_en),
      .i_csr_mie_en     (i_csr_mie_en),
      .i_csr_mcause_en  (i_csr_mcause_en),
      .i_csr_en         (i_csr_en),
      .i_csr_addr       (i_csr_addr),
      .cmt              (cmt_if.capture)
   );

   rvmon_shadow_regs u_shadow (
      .i_clk         (i_clk),
      .i_rst_n       (i_rst_n),
      .cmt           (cmt_if.shadow),
      .i_class       (dec_class),
      .i_class_valid (dec_class_valid),
      .i_psel        (i_psel),
      .i_penable     (i_penable),
      .i_pwrite      (i_pwrite),
      .i_paddr       (i_paddr),
      .o_prdata      (o_prdata),
      .o_pready      (o_pready),
      .o_pslverr     (o_pslverr)
   );

endmodule

//--- include/rvmon_macros.svh
`ifndef RVMON_MACROS_SVH
`define RVMON_MACROS_SVH

// ########################################
// data path widths
// ########################################

// serial width of the write-back stream, either 1 or 4.
`define RVMON_W 1

`define RVMON_XLEN 32

// ########################################
// APB address map
// ########################################

`define RVMON_ADDR_W 8
// general purpose registers occupy 0x00 up to the CSR block.
`define RVMON_CSR_BASE 8'h80
`define RVMON_RETIRE_ADDR 8'h9C
`define RVMON_CLASS_ADDR 8'hA0

`endif

//--- run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -Wno-fatal \
   --top-module rvmon_tb -Mdir "$BUILD" -f src.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$BUILD/Vrvmon_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

# the log decides the verdict.
if grep -q "Test FAILED" "$LOG"; then
   exit 1
fi
exit 0

//--- src.f
+incdir+include
hw/rvmon_pkg.sv
hw/rvmon_commit_if.sv
hw/rvmon_insn_decode.sv
hw/rvmon_serial_capture.sv
hw/rvmon_shadow_regs.sv
hw/rvmon_top.sv
verification/rvmon_checker.sv
verification/rvmon_tb.sv

//--- verification/rvmon_checker.sv
`timescale 1ns/1ps
`include "rvmon_macros.svh"

module rvmon_checker (
   input logic                 i_clk,
   input logic                 i_rst_n,
   input logic                 i_psel,
   input logic                 i_penable,
   input logic                 i_pwrite,
   input rvmon_pkg::apb_addr_t i_paddr,
   input logic                 o_pslverr,
   input rvmon_pkg::word_t     o_prdata,
   input rvmon_pkg::word_t     retire_cnt
);

   // ########################################
   // APB slave
   // ########################################

   // the last class only ever holds a decoder code, and OTHER is the largest one.
   class_in_range: assert property (@(posedge i_clk)
      (i_psel && i_penable && !i_pwrite && (i_paddr == `RVMON_CLASS_ADDR))
      |-> (o_prdata <= 32'd46))
      else $error("last class read back above the OTHER code");

   err_in_access: assert property (@(posedge i_clk) o_pslverr |-> (i_psel && i_penable))
      else $error("o_pslverr outside an access cycle");

   write_refused: assert property (@(posedge i_clk) (i_psel && i_penable && i_pwrite) |-> o_pslverr)
      else $error("write access completed without o_pslverr");

   idle_rdata: assert property (@(posedge i_clk) !(i_psel && i_penable) |-> (o_prdata == '0))
      else $error("o_prdata not zero outside an access cycle");

   // ########################################
   // retire counter
   // ########################################

   // the counter only ever moves up by one per retire pulse.
   retire_step: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (retire_cnt != $past(retire_cnt)) |-> (retire_cnt == $past(retire_cnt) + 32'd1))
      else $error("retire counter jumped");

endmodule

//--- verification/rvmon_tb.sv
`timescale 1ns/1ps
`include "rvmon_macros.svh"

module rvmon_tb;
   import rvmon_pkg::*;

   localparam int BEATS = `RVMON_XLEN / `RVMON_W;
   localparam int N_TXN = 300;
   // each transaction needs well under BEATS + 20 cycles.
   localparam int WDOG_CYCLES = N_TXN * (BEATS + 20);
   localparam logic [6:0] OPCODES [11] = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03,
                                           7'h23, 7'h13, 7'h33, 7'h0f, 7'h73};

   logic i_clk, i_rst_n, i_ibus_ack, i_wen0, i_cnt_en, i_csr_in, i_cnt_done, i_ctrl_pc_en;
   logic i_csr_mstatus_en, i_csr_mie_en, i_csr_mcause_en, i_csr_en;
   logic i_psel, i_penable, i_pwrite, o_pready, o_pslverr;
   logic [1:0] i_csr_addr;
   word_t i_ibus_rdt, o_prdata;
   slice_t i_wdata0;
   reg_idx_t i_rd_addr;
   apb_addr_t i_paddr;

   integer seed;
   int word_errs, class_errs, flag_errs;

   word_t m_x [0:31];
   word_t m_csr [1:7];
   word_t m_csr_shift;
   word_t m_retire;
   insn_class_t m_last;

   rvmon_top dut0 (.*);

   bind rvmon_shadow_regs rvmon_checker chk0 (.*);

   initial begin
      i_clk = 1'b0;
      forever #5 i_clk = ~i_clk;
   end

   initial begin
      repeat (WDOG_CYCLES) @(posedge i_clk);
      $display("timeout: the run did not finish within %0d cycles", WDOG_CYCLES);
      $display("Test FAILED");
      $finish;
   end

   // ########################################
   // reference model
   // ########################################

   // class codes follow the RV32I and Zicsr tables, 46 when nothing fits.
   function automatic insn_class_t model_class(input word_t w);
      logic [2:0] f3;
      logic [6:0] f7;
      insn_class_t c;
      f3 = w[14:12];
      f7 = w[31:25];
      c = 6'd46;
      case (w[6:0])
         7'h37: c = 6'd0;
         7'h17: c = 6'd1;
         7'h6f: c = 6'd2;
         7'h67: if (f3 == 3'd0) c = 6'd3;
         7'h63: begin
            if (f3 < 3'd2) c = 6'd4 + f3;
            else if (f3 > 3'd3) c = 6'd2 + f3;
         end
         7'h03: begin
            if (f3 < 3'd3) c = 6'd10 + f3;
            else if (f3 == 3'd4 || f3 == 3'd5) c = 6'd9 + f3;
         end
         7'h23: if (f3 < 3'd3) c = 6'd15 + f3;
         7'h13: begin
            if (f3 == 3'd1) begin
               if (f7 == 7'h00) c = 6'd24;
            end else if (f3 == 3'd5) begin
               if (f7 == 7'h00) c = 6'd25;
               else if (f7 == 7'h20) c = 6'd26;
            end else begin
               c = (f3 == 3'd0) ? 6'd18 : (f3 < 3'd5) ? 6'd17 + f3 : 6'd16 + f3;
            end
         end
         7'h33: begin
            if (f7 == 7'h00) c = (f3 == 3'd0) ? 6'd27 : (f3 < 3'd6) ? 6'd28 + f3 : 6'd29 + f3;
            else if (f7 == 7'h20 && f3 == 3'd0) c = 6'd28;
            else if (f7 == 7'h20 && f3 == 3'd5) c = 6'd34;
         end
         7'h0f: if (f3 == 3'd0) c = 6'd37;
         7'h73: begin
            if (w == 32'h0000_0073) c = 6'd38;
            else if (w == 32'h0010_0073) c = 6'd39;
            else if (f3 != 3'd0 && f3 != 3'd4) c = (f3 < 3'd4) ? 6'd39 + f3 : 6'd38 + f3;
         end
         default: c = 6'd46;
      endcase
      return c;
   endfunction

   function automatic word_t model_read(input apb_addr_t a);
      if (a < `RVMON_CSR_BASE) return m_x[a[6:2]];
      if (a < `RVMON_RETIRE_ADDR) return m_csr[((a - `RVMON_CSR_BASE) >> 2) + 1];
      if (a == `RVMON_RETIRE_ADDR) return m_retire;
      return word_t'(m_last);
   endfunction

   // ########################################
   // compare and bus tasks
   // ########################################

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         word_errs++;
         $display("** Error %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_class(input string name, input insn_class_t got, input insn_class_t exp);
      if (got !== exp) begin
         class_errs++;
         $display("** Error %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         flag_errs++;
         $display("** Error %s: got %h, expected %h", name, got, exp);
      end
   endtask

   // one APB transfer, entered and left on a falling edge.
   task automatic apb_xfer(input logic wr, input apb_addr_t a, output word_t d, output logic e);
      i_psel = 1'b1;
      i_penable = 1'b0;
      i_pwrite = wr;
      i_paddr = a;
      @(negedge i_clk);
      i_penable = 1'b1;
      @(posedge i_clk);
      check_flag("o_pready", o_pready, 1'b1);
      d = o_prdata;
      e = o_pslverr;
      @(negedge i_clk);
      i_psel = 1'b0;
      i_penable = 1'b0;
      i_pwrite = 1'b0;
   endtask

   task automatic read_expect(input apb_addr_t a);
      word_t d;
      logic e;
      apb_xfer(1'b0, a, d, e);
      check_flag($sformatf("o_pslverr[%h]", a), e, 1'b0);
      check_word($sformatf("o_prdata[%h]", a), d, model_read(a));
   endtask

   task automatic sweep_all();
      for (int a = 0; a <= `RVMON_CLASS_ADDR; a += 4) begin
         read_expect(apb_addr_t'(a));
      end
   endtask

   // writes, unaligned reads and reads past the map are all refused.
   task automatic bad_accesses();
      word_t r;
      word_t d;
      logic e;
      r = $random(seed);
      apb_xfer(1'b1, {r[7:2], 2'b00}, d, e);
      check_flag("o_pslverr on write", e, 1'b1);
      apb_xfer(1'b0, {r[15:10], r[9], 1'b1}, d, e);
      check_flag("o_pslverr on unaligned read", e, 1'b1);
      apb_xfer(1'b0, {2'b11, r[21:16]}, d, e);
      check_flag("o_pslverr on unmapped read", e, 1'b1);
   endtask

   // ########################################
   // instruction transaction
   // ########################################

   task automatic run_txn();
      word_t insn;
      word_t r;
      word_t rd_word;
      word_t d;
      logic e;
      csr_sel_t sel;
      logic pc_en;
      r = $random(seed);
      insn = $random(seed);
      if (r[3:0] < 4'd11) insn[6:0] = OPCODES[r[3:0]];
      if (r[4]) insn[31:25] = r[5] ? 7'h20 : 7'h00;
      if (r[7:6] == 2'b11) insn = r[8] ? 32'h0010_0073 : 32'h0000_0073;
      i_ibus_ack = 1'b1;
      i_ibus_rdt = insn;
      @(negedge i_clk);
      i_ibus_ack = 1'b0;
      r = $random(seed);
      i_rd_addr = r[4:0];
      {i_csr_en, i_csr_mcause_en, i_csr_mie_en, i_csr_mstatus_en} = r[11:8];
      i_csr_addr = r[13:12];
      if (r[8]) sel = 3'd1;
      else if (r[9]) sel = 3'd2;
      else if (r[10]) sel = 3'd3;
      else if (r[11]) sel = 3'd4 + r[13:12];
      else sel = 3'd0;
      for (int k = 0; k < BEATS; k++) begin
         r = $random(seed);
         i_wen0 = 1'b1;
         i_wdata0 = r[`RVMON_W-1:0];
         i_cnt_en = 1'b1;
         i_csr_in = r[16];
         i_ctrl_pc_en = r[17];
         i_cnt_done = (k == BEATS - 1);
         rd_word[k*`RVMON_W +: `RVMON_W] = r[`RVMON_W-1:0];
         m_csr_shift = {r[16], m_csr_shift[`RVMON_XLEN-1:1]};
         @(negedge i_clk);
      end
      pc_en = i_ctrl_pc_en;
      {i_wen0, i_cnt_en, i_cnt_done, i_ctrl_pc_en} = 4'b0;
      if (i_rd_addr != 5'd0) m_x[i_rd_addr] = rd_word;
      if (sel != 3'd0) m_csr[sel] = m_csr_shift;
      if (pc_en) begin
         m_retire++;
         m_last = model_class(insn);
      end
      repeat (2) @(negedge i_clk);
      read_expect({1'b0, i_rd_addr, 2'b00});
      if (sel != 3'd0) read_expect(apb_addr_t'(`RVMON_CSR_BASE + 4 * (sel - 1)));
      r = $random(seed);
      read_expect(apb_addr_t'(`RVMON_CSR_BASE + 4 * (r[2:0] % 7)));
      read_expect(`RVMON_RETIRE_ADDR);
      apb_xfer(1'b0, `RVMON_CLASS_ADDR, d, e);
      check_flag("o_pslverr[a0]", e, 1'b0);
      check_class("last_class", d[5:0], m_last);
   endtask

   initial begin
      seed = 49;
      word_errs = 0;
      class_errs = 0;
      flag_errs = 0;
      {i_rst_n, i_ibus_ack, i_wen0, i_cnt_en, i_csr_in, i_cnt_done, i_ctrl_pc_en} = '0;
      {i_csr_mstatus_en, i_csr_mie_en, i_csr_mcause_en, i_csr_en, i_csr_addr} = '0;
      {i_psel, i_penable, i_pwrite, i_paddr, i_ibus_rdt, i_wdata0, i_rd_addr} = '0;
      for (int i = 0; i < 32; i++) m_x[i] = '0;
      for (int j = 1; j < 8; j++) m_csr[j] = '0;
      m_csr_shift = '0;
      m_retire = '0;
      m_last = '0;
      repeat (5) @(posedge i_clk);
      @(negedge i_clk);
      i_rst_n = 1'b1;
      sweep_all();
      for (int t = 0; t < N_TXN; t++) begin
         run_txn();
         if (t % 10 == 9) bad_accesses();
      end
      sweep_all();
      $display("errors: %0d word, %0d class, %0d flag", word_errs, class_errs, flag_errs);
      if (word_errs + class_errs + flag_errs == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule
